// ==== mem_subsys.f ====
mem_pkg.sv
mem_bank_if.sv
mem_access_arb.sv
sram_bank.sv
mem_resp_router.sv
mem_subsys.sv
tb_mem_subsys.sv

// ==== Makefile ====
# Verilator flow for the banked memory subsystem

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= mem_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TB PASSED
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) \
		--top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_mem_subsys.sv ====
module tb_mem_subsys;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_pkg::*;

    localparam int BUSY_LIMIT  = 20;
    localparam int DRAIN_LIMIT = 20;
    localparam int RAND_CYCLES = 300;

    logic              clk;
    logic              rst_n;
    logic              imem_en;
    logic [ADDR_W-1:0] imem_addr;
    logic [DATA_W-1:0] imem_rdata;
    logic [BAD_W-1:0]  imem_bad;
    logic              imem_busy;
    logic              dmem_en;
    logic [ADDR_W-1:0] dmem_addr;
    logic              dmem_write;
    logic [STRB_W-1:0] dmem_strb;
    logic [DATA_W-1:0] dmem_wdata;
    logic [DATA_W-1:0] dmem_rdata;
    logic [BAD_W-1:0]  dmem_bad;
    logic              dmem_busy;

    integer seed = 98;
    int     cyc;
    int     err_count;
    int     check_count;
    // bank contents indexed by {bank, word}
    logic [DATA_W-1:0] model_mem [NUM_BANKS*BANK_WORDS];
    // responses in flight, port 1 is the data port
    logic                    exp_port [$];
    logic [ADDR_W-1:0]       exp_addr [$];
    logic [BAD_W+DATA_W-1:0] exp_res [$];
    int                      exp_due [$];

    mem_subsys i_mem_subsys (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [ADDR_W-1:0] rand_word();
        logic [ADDR_W-1:0] r;
        r = $random(seed);
        return r;
    endfunction

    function automatic logic [ADDR_W-1:0] word_addr(input int bank, input int word);
        return ADDR_W'((bank << 12) | (word << 2));
    endfunction

    // mostly the first 8 words of each bank, some just outside or misaligned
    function automatic logic [ADDR_W-1:0] pool_addr();
        logic [ADDR_W-1:0] r;
        logic [ADDR_W-1:0] a;
        r = rand_word();
        a = word_addr(int'(r[1:0]), int'(r[4:2]));
        if (r[7:5] == 3'd6) begin
            a = a | (32'h0000_4000 << r[10:8]);
        end else if (r[7:5] == 3'd7) begin
            a[1:0] = (r[9:8] == 2'b00) ? 2'b10 : r[9:8];
        end
        return a;
    endfunction

    // expected {bad, rdata}, updates the model on writes
    function automatic logic [BAD_W+DATA_W-1:0] ref_access(input logic is_data,
            input logic [ADDR_W-1:0] addr, input logic write,
            input logic [STRB_W-1:0] strb, input logic [DATA_W-1:0] wdata);
        logic [BAD_W-1:0]  bad;
        logic [DATA_W-1:0] rdata;
        logic [DATA_W-1:0] word;
        int                idx;
        bad   = BAD_NONE;
        rdata = '0;
        idx   = int'(addr[13:2]);
        if (addr[31:14] != '0) begin
            bad = BAD_UNMAPPED;
        end else if (addr[1:0] != 2'b00) begin
            bad = BAD_MISALIGN;
        end else if (is_data && write) begin
            word = model_mem[idx];
            for (int i = 0; i < STRB_W; i++) begin
                if (strb[i]) begin
                    word[i*8 +: 8] = wdata[i*8 +: 8];
                end
            end
            model_mem[idx] = word;
        end else begin
            rdata = model_mem[idx];
        end
        return {bad, rdata};
    endfunction

    task automatic check_equal(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                               input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // one cycle of requests, decided at the falling edge
    task automatic drive_cycle(input logic i_en, input logic [ADDR_W-1:0] i_addr,
            input logic d_en, input logic d_write, input logic [STRB_W-1:0] d_strb,
            input logic [ADDR_W-1:0] d_addr, input logic [DATA_W-1:0] d_wdata,
            output logic i_acc, output logic d_acc);
        @(posedge clk);
        imem_en    <= i_en;
        imem_addr  <= i_addr;
        dmem_en    <= d_en;
        dmem_write <= d_write;
        dmem_strb  <= d_strb;
        dmem_addr  <= d_addr;
        dmem_wdata <= d_wdata;
        @(negedge clk);
        i_acc = i_en && !imem_busy;
        d_acc = d_en && !dmem_busy;
        if (d_acc) begin
            exp_port.push_back(1'b1);
            exp_addr.push_back(d_addr);
            exp_res.push_back(ref_access(1'b1, d_addr, d_write, d_strb, d_wdata));
            exp_due.push_back(cyc + 1);
        end
        if (i_acc) begin
            exp_port.push_back(1'b0);
            exp_addr.push_back(i_addr);
            exp_res.push_back(ref_access(1'b0, i_addr, 1'b0, '1, '0));
            exp_due.push_back(cyc + 1);
        end
    endtask

    // repeats the refused port until both are taken
    task automatic access_pair(input logic i_en, input logic [ADDR_W-1:0] i_addr,
            input logic d_en, input logic d_write, input logic [STRB_W-1:0] d_strb,
            input logic [ADDR_W-1:0] d_addr, input logic [DATA_W-1:0] d_wdata,
            output logic i_busy_first, output logic d_busy_first);
        logic pend_i;
        logic pend_d;
        logic i_acc;
        logic d_acc;
        int   tries;
        pend_i = i_en;
        pend_d = d_en;
        tries  = 0;
        i_busy_first = 1'b0;
        d_busy_first = 1'b0;
        while ((pend_i || pend_d) && tries < BUSY_LIMIT) begin
            drive_cycle(pend_i, i_addr, pend_d, d_write, d_strb, d_addr, d_wdata, i_acc, d_acc);
            if (tries == 0) begin
                i_busy_first = pend_i && !i_acc;
                d_busy_first = pend_d && !d_acc;
            end
            pend_i = pend_i && !i_acc;
            pend_d = pend_d && !d_acc;
            tries++;
        end
        if (pend_i || pend_d) begin
            err_count++;
            $display("imem or dmem stayed busy for %0d cycles at %h / %h",
                     BUSY_LIMIT, i_addr, d_addr);
        end
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        int n;
        n = 0;
        @(posedge clk);
        imem_en <= 1'b0;
        dmem_en <= 1'b0;
        while (exp_due.size() > 0 && n < DRAIN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (exp_due.size() > 0) begin
            err_count++;
            $display("responses of test %0d never arrived", num);
        end
        $display("test %0d %s: %0d errors", num, name, err_count - errs_before);
    endtask

    always @(negedge clk) begin : compare
        logic                    port;
        logic [ADDR_W-1:0]       addr;
        logic [BAD_W+DATA_W-1:0] res;
        logic [1:0]              seen;
        seen = 2'b00;
        while (rst_n && exp_due.size() > 0 && exp_due[0] == cyc) begin
            port = exp_port.pop_front();
            addr = exp_addr.pop_front();
            res  = exp_res.pop_front();
            void'(exp_due.pop_front());
            seen[port] = 1'b1;
            check_equal(port ? dmem_rdata : imem_rdata, res[DATA_W-1:0],
                        $sformatf("%s rdata at %h", port ? "dmem" : "imem", addr));
            check_equal(DATA_W'(port ? dmem_bad : imem_bad), DATA_W'(res[BAD_W+DATA_W-1:DATA_W]),
                        $sformatf("%s bad at %h", port ? "dmem" : "imem", addr));
        end
        // nothing in flight, outputs stay zero
        if (rst_n && !seen[0]) begin
            check_equal(imem_rdata | DATA_W'(imem_bad), '0, "imem idle output");
        end
        if (rst_n && !seen[1]) begin
            check_equal(dmem_rdata | DATA_W'(dmem_bad), '0, "dmem idle output");
        end
    end

    initial begin : main
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] r;
        logic              ib;
        logic              db;
        logic              i_acc;
        logic              d_acc;
        int                errs;
        rst_n      = 1'b0;
        imem_en    = 1'b0;
        imem_addr  = '0;
        dmem_en    = 1'b0;
        dmem_addr  = '0;
        dmem_write = 1'b0;
        dmem_strb  = '0;
        dmem_wdata = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        errs = err_count;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int w = 0; w < 8; w++) begin
                a = word_addr(b, w);
                access_pair(1'b0, '0, 1'b1, 1'b1, 4'hf, a, rand_word(), ib, db);
                access_pair(1'b0, '0, 1'b1, 1'b1, 4'(rand_word()), a, rand_word(), ib, db);
            end
        end
        for (int i = 0; i < NUM_BANKS * 8; i++) begin
            access_pair(1'b0, '0, 1'b1, 1'b0, 4'hf, word_addr(i / 8, i % 8), '0, ib, db);
        end
        end_test(1, "data writes and reads", errs);

        errs = err_count;
        for (int i = 0; i < NUM_BANKS * 8; i++) begin
            access_pair(1'b1, word_addr(i / 8, i % 8), 1'b0, 1'b0, '0, '0, '0, ib, db);
        end
        end_test(2, "fetch reads", errs);

        errs = err_count;
        for (int b = 0; b < NUM_BANKS; b++) begin
            access_pair(1'b1, word_addr(b, 0), 1'b1, 1'(b), 4'b0110, word_addr(b, b + 1),
                        rand_word(), ib, db);
            check_equal(DATA_W'(ib), 1, "imem busy on shared bank");
            check_equal(DATA_W'(db), 0, "dmem busy on shared bank");
        end
        end_test(3, "same bank conflict", errs);

        errs = err_count;
        for (int b = 0; b < NUM_BANKS; b++) begin
            access_pair(1'b1, word_addr(b, 2), 1'b1, 1'b0, 4'hf, word_addr((b + 1) % 4, 3),
                        '0, ib, db);
            check_equal(DATA_W'(ib | db), 0, "busy on different banks");
        end
        end_test(4, "different banks", errs);

        errs = err_count;
        access_pair(1'b1, 32'h0004_1000, 1'b1, 1'b1, 4'hf, 32'h0000_4008, 32'hdead_beef, ib, db);
        check_equal(DATA_W'(ib | db), 0, "busy on unmapped access");
        access_pair(1'b1, word_addr(2, 3) | 1, 1'b1, 1'b1, 4'hf, word_addr(1, 1) | 2,
                    32'hcafe_f00d, ib, db);
        check_equal(DATA_W'(ib | db), 0, "busy on misaligned access");
        access_pair(1'b1, word_addr(1, 1), 1'b1, 1'b0, 4'hf, word_addr(0, 2), '0, ib, db);
        end_test(5, "address faults", errs);

        errs = err_count;
        for (int n = 0; n < RAND_CYCLES; n++) begin
            r = rand_word();
            drive_cycle(r[0], pool_addr(), r[1], r[2], r[7:4], pool_addr(), rand_word(),
                        i_acc, d_acc);
        end
        end_test(6, "random traffic", errs);

        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== mem_subsys.sv ====
module mem_subsys (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          imem_en,
    input  logic [mem_pkg::ADDR_W-1:0]    imem_addr,
    output logic [mem_pkg::DATA_W-1:0]    imem_rdata,
    output logic [mem_pkg::BAD_W-1:0]     imem_bad,
    output logic                          imem_busy,
    input  logic                          dmem_en,
    input  logic [mem_pkg::ADDR_W-1:0]    dmem_addr,
    input  logic                          dmem_write,
    input  logic [mem_pkg::STRB_W-1:0]    dmem_strb,
    input  logic [mem_pkg::DATA_W-1:0]    dmem_wdata,
    output logic [mem_pkg::DATA_W-1:0]    dmem_rdata,
    output logic [mem_pkg::BAD_W-1:0]     dmem_bad,
    output logic                          dmem_busy
);
    import mem_pkg::*;

    mem_addr_u             imem_addr_u;
    mem_addr_u             dmem_addr_u;
    logic                  imem_take;
    logic [BANK_IDX_W-1:0] imem_bank;
    logic [BAD_W-1:0]      imem_fault;
    logic                  dmem_take;
    logic [BANK_IDX_W-1:0] dmem_bank;
    logic [BAD_W-1:0]      dmem_fault;

    // flat address in, field view used downstream
    assign imem_addr_u.raw = imem_addr;
    assign dmem_addr_u.raw = dmem_addr;

    mem_bank_if bank_if [NUM_BANKS] ();

    mem_access_arb u_mem_access_arb (
        .clk        ( clk         ),
        .rst_n      ( rst_n       ),
        .imem_en    ( imem_en     ),
        .imem_addr  ( imem_addr_u ),
        .dmem_en    ( dmem_en     ),
        .dmem_write ( dmem_write  ),
        .dmem_strb  ( dmem_strb   ),
        .dmem_addr  ( dmem_addr_u ),
        .dmem_wdata ( dmem_wdata  ),
        .imem_busy  ( imem_busy   ),
        .dmem_busy  ( dmem_busy   ),
        .imem_take  ( imem_take   ),
        .imem_bank  ( imem_bank   ),
        .imem_fault ( imem_fault  ),
        .dmem_take  ( dmem_take   ),
        .dmem_bank  ( dmem_bank   ),
        .dmem_fault ( dmem_fault  ),
        .banks      ( bank_if     )
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        sram_bank u_sram_bank (
            .clk  ( clk        ),
            .bank ( bank_if[b] )
        );
    end

    mem_resp_router u_mem_resp_router (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .imem_take  ( imem_take  ),
        .imem_bank  ( imem_bank  ),
        .imem_fault ( imem_fault ),
        .dmem_take  ( dmem_take  ),
        .dmem_bank  ( dmem_bank  ),
        .dmem_fault ( dmem_fault ),
        .dmem_write ( dmem_write ),
        .banks      ( bank_if    ),
        .imem_rdata ( imem_rdata ),
        .imem_bad   ( imem_bad   ),
        .dmem_rdata ( dmem_rdata ),
        .dmem_bad   ( dmem_bad   )
    );

endmodule

// ==== mem_resp_router.sv ====
module mem_resp_router (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           imem_take,
    input  logic [mem_pkg::BANK_IDX_W-1:0] imem_bank,
    input  logic [mem_pkg::BAD_W-1:0]      imem_fault,
    input  logic                           dmem_take,
    input  logic [mem_pkg::BANK_IDX_W-1:0] dmem_bank,
    input  logic [mem_pkg::BAD_W-1:0]      dmem_fault,
    input  logic                           dmem_write,
    mem_bank_if.router                     banks [mem_pkg::NUM_BANKS],
    output logic [mem_pkg::DATA_W-1:0]     imem_rdata,
    output logic [mem_pkg::BAD_W-1:0]      imem_bad,
    output logic [mem_pkg::DATA_W-1:0]     dmem_rdata,
    output logic [mem_pkg::BAD_W-1:0]      dmem_bad
);
    import mem_pkg::*;

    logic [NUM_BANKS-1:0]  cs_v;
    logic [NUM_BANKS-1:0]  gd_v;
    logic [DATA_W-1:0]     rd_v [NUM_BANKS];

    logic                  imem_rd;
    logic                  dmem_rd;
    logic                  imem_rd_q;
    logic                  dmem_rd_q;
    logic [BANK_IDX_W-1:0] imem_bank_q;
    logic [BANK_IDX_W-1:0] dmem_bank_q;
    logic [BAD_W-1:0]      imem_bad_q;
    logic [BAD_W-1:0]      dmem_bad_q;

    // flatten interface array so it can be indexed
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_gather
        assign cs_v[b] = banks[b].cs;
        assign gd_v[b] = banks[b].grant_d;
        assign rd_v[b] = banks[b].rdata;
    end

    // a read counts only if the bank really went to that port
    assign imem_rd = imem_take && imem_fault == BAD_NONE
                     && cs_v[imem_bank] && !gd_v[imem_bank];
    assign dmem_rd = dmem_take && !dmem_write && dmem_fault == BAD_NONE
                     && cs_v[dmem_bank] && gd_v[dmem_bank];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            imem_rd_q  <= 1'b0;
            dmem_rd_q  <= 1'b0;
            imem_bad_q <= BAD_NONE;
            dmem_bad_q <= BAD_NONE;
        end else begin
            imem_rd_q  <= imem_rd;
            dmem_rd_q  <= dmem_rd;
            imem_bad_q <= imem_take ? imem_fault : BAD_NONE;
            dmem_bad_q <= dmem_take ? dmem_fault : BAD_NONE;
        end
    end

    always_ff @(posedge clk) begin
        imem_bank_q <= imem_bank;
        dmem_bank_q <= dmem_bank;
    end

    // zero for writes, faults and idle cycles
    assign imem_rdata = imem_rd_q ? rd_v[imem_bank_q] : '0;
    assign dmem_rdata = dmem_rd_q ? rd_v[dmem_bank_q] : '0;
    assign imem_bad   = imem_bad_q;
    assign dmem_bad   = dmem_bad_q;

    a_fault_excludes_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        !((imem_bad_q != BAD_NONE && imem_rd_q) || (dmem_bad_q != BAD_NONE && dmem_rd_q))
    );

endmodule

// ==== sram_bank.sv ====
module sram_bank (
    input  logic    clk,
    mem_bank_if.bank bank
);
    import mem_pkg::*;

    logic [DATA_W-1:0] mem [BANK_WORDS];

    // single port, write or read per cycle
    always_ff @(posedge clk) begin
        if (bank.cs) begin
            if (bank.we) begin
                for (int i = 0; i < STRB_W; i++) begin
                    if (bank.byte_en[i]) begin
                        mem[bank.word][i*8 +: 8] <= bank.wdata[i*8 +: 8];
                    end
                end
            end else begin
                // read data shows up next cycle
                bank.rdata <= mem[bank.word];
            end
        end
    end

    // arbiter only raises we together with a chip select
    a_we_needs_cs: assert property (
        @(posedge clk) bank.we |-> bank.cs
    );

endmodule

// ==== mem_access_arb.sv ====
module mem_access_arb (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               imem_en,
    input  mem_pkg::mem_addr_u                 imem_addr,
    input  logic                               dmem_en,
    input  logic                               dmem_write,
    input  logic [mem_pkg::STRB_W-1:0]         dmem_strb,
    input  mem_pkg::mem_addr_u                 dmem_addr,
    input  logic [mem_pkg::DATA_W-1:0]         dmem_wdata,
    output logic                               imem_busy,
    output logic                               dmem_busy,
    output logic                               imem_take,
    output logic [mem_pkg::BANK_IDX_W-1:0]     imem_bank,
    output logic [mem_pkg::BAD_W-1:0]          imem_fault,
    output logic                               dmem_take,
    output logic [mem_pkg::BANK_IDX_W-1:0]     dmem_bank,
    output logic [mem_pkg::BAD_W-1:0]          dmem_fault,
    mem_bank_if.arb                            banks [mem_pkg::NUM_BANKS]
);
    import mem_pkg::*;

    logic [NUM_BANKS-1:0] i_hit;
    logic [NUM_BANKS-1:0] d_hit;

    // unmapped wins over misaligned
    function automatic logic [BAD_W-1:0] addr_fault(input mem_addr_u a);
        logic [BAD_W-1:0] code;
        code = BAD_NONE;
        if (a.fld.region != '0) begin
            code = BAD_UNMAPPED;
        end else if (a.fld.byte_off != '0) begin
            code = BAD_MISALIGN;
        end
        return code;
    endfunction

    assign imem_fault = addr_fault(imem_addr);
    assign dmem_fault = addr_fault(dmem_addr);
    assign imem_bank  = imem_addr.fld.bank;
    assign dmem_bank  = dmem_addr.fld.bank;

    // one-hot bank wish per port, faulted requests touch no bank
    always_comb begin
        i_hit = '0;
        d_hit = '0;
        if (imem_en && imem_fault == BAD_NONE) begin
            i_hit[imem_bank] = 1'b1;
        end
        if (dmem_en && dmem_fault == BAD_NONE) begin
            d_hit[dmem_bank] = 1'b1;
        end
    end

    // data port has priority, so only fetch can lose
    assign imem_busy = |(i_hit & d_hit);
    assign dmem_busy = 1'b0;

    assign imem_take = imem_en && !imem_busy;
    assign dmem_take = dmem_en && !dmem_busy;

    // steer winner onto each bank
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank_drv
        assign banks[b].cs      = d_hit[b] | i_hit[b];
        assign banks[b].grant_d = d_hit[b];
        assign banks[b].we      = d_hit[b] & dmem_write;
        assign banks[b].word    = d_hit[b] ? dmem_addr.fld.word : imem_addr.fld.word;
        // fetch always reads the full word
        assign banks[b].byte_en = d_hit[b] ? dmem_strb : {STRB_W{1'b1}};
        assign banks[b].wdata   = d_hit[b] ? dmem_wdata : '0;

        // a taken fetch finds its bank free of the data port
        a_one_port_per_bank: assert property (
            @(posedge clk) disable iff (!rst_n)
            (imem_take && imem_fault == BAD_NONE && imem_bank == BANK_IDX_W'(b))
                |-> (banks[b].cs && !banks[b].grant_d)
        );
    end

    // a faulted fetch is taken at once
    a_no_busy_on_fault: assert property (
        @(posedge clk) disable iff (!rst_n)
        (imem_en && imem_fault != BAD_NONE) |-> !imem_busy
    );

endmodule

// ==== mem_bank_if.sv ====
interface mem_bank_if;
    import mem_pkg::*;

    // request side
    logic                  cs;
    logic                  we;
    logic [WORD_IDX_W-1:0] word;
    logic [STRB_W-1:0]     byte_en;
    logic [DATA_W-1:0]     wdata;

    // response side
    logic [DATA_W-1:0]     rdata;

    // set when the data port owns this bank in the cycle
    logic                  grant_d;

    modport arb (
        output cs,
        output we,
        output word,
        output byte_en,
        output wdata,
        output grant_d
    );

    modport bank (
        input  cs,
        input  we,
        input  word,
        input  byte_en,
        input  wdata,
        output rdata
    );

    modport router (
        input cs,
        input grant_d,
        input rdata
    );

endinterface

// ==== mem_pkg.sv ====
package mem_pkg;

    // word and bus geometry
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // bank layout, four banks of 1k words
    localparam int NUM_BANKS  = 4;
    localparam int BANK_IDX_W = 2;
    localparam int BANK_WORDS = 1024;
    localparam int WORD_IDX_W = 10;

    // byte offset inside a word
    localparam int BYTE_OFF_W = 2;

    // everything above bank, word and byte fields
    localparam int REGION_W = ADDR_W - BANK_IDX_W - WORD_IDX_W - BYTE_OFF_W;

    // fault codes returned on the bad lines
    localparam int BAD_W = 2;
    localparam logic [BAD_W-1:0] BAD_NONE     = 2'd0;
    localparam logic [BAD_W-1:0] BAD_UNMAPPED = 2'd1;
    localparam logic [BAD_W-1:0] BAD_MISALIGN = 2'd2;

    // one physical address, flat or split into bank fields
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [REGION_W-1:0]   region;
            logic [BANK_IDX_W-1:0] bank;
            logic [WORD_IDX_W-1:0] word;
            logic [BYTE_OFF_W-1:0] byte_off;
        } fld;
    } mem_addr_u;

endpackage
